// File: compile.f
source/clip_pkg.sv
source/object_scanner.sv
source/line_splitter.sv
source/line_fifo.sv
source/clip_engine.sv
source/clipping_unit.sv
tb/clipping_unit_assert.sv
tb/clipping_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = clipping_unit_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/clipping_unit_tb.sv
module clipping_unit_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import clip_pkg::*;

    localparam int refresh    = 300;
    localparam int max_cycles = 4 * refresh + 500;
    localparam int max_x      = 640;
    localparam int max_y      = 480;

    logic                 clk;
    logic                 rst_n;
    logic [num_slots-1:0] obj_map;
    object_t              obj = '0;
    logic                 raster_ready = 1'b0;
    logic [4:0]           addr;
    logic                 read_en;
    out_line_t            line_out;
    logic                 vld;
    object_t              mem [num_slots];
    logic                 rd_pend = 1'b0;
    logic [4:0]           rd_addr = '0;
    logic                 ready_hold = 1'b0;  // forces the rasterizer to stall
    int                   cyc = 0;
    out_line_t            exp_q [$];

    clipping_unit #(.refresh_period(refresh), .fifo_depth(128)) i_clipping_unit (
        .clk, .rst_n, .obj_map, .obj, .raster_ready, .addr, .read_en, .line_out, .vld
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic end_in_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic string fmt_line(out_line_t l);
        return $sformatf("(%0d,%0d)-(%0d,%0d) color %0d", l.x0, l.y0, l.x1, l.y1, l.color);
    endfunction

    // slot % 8 picks the case, the slot number shifts coordinates and color
    function automatic object_t make_obj(int slot);
        object_t   o;
        obj_kind_t kinds [8];
        int        vx [4];
        int        vy [4];
        int        d;
        kinds = '{kind_line, kind_line, kind_line, kind_point,
                  kind_tri, kind_quad, kind_point, kind_line};
        d = slot;
        case (slot % 8)
            0: begin  // inside
                vx = '{10 + d, 300 + d, d, d};
                vy = '{20 + d, 400 - d, d, d};
            end
            1: begin  // both ends left of the screen
                vx = '{-50 - d, -5, d, d};
                vy = '{10, 300 + d, d, d};
            end
            2: begin
                vx = '{100 + d, 300, d, d};
                vy = '{200, 600 + d, d, d};
            end
            3: begin
                vx = '{320 + d, d, d, d};
                vy = '{240, d, d, d};
            end
            4: begin  // v1 beyond the right edge
                vx = '{500, 700 + d, 550, d};
                vy = '{100 + d, 200, 300, d};
            end
            5: begin  // crosses top and left edges
                vx = '{-40 - d, 200, 300, 100};
                vy = '{100, -30, 200, 300 + d};
            end
            6: begin
                vx = '{700, d, d, d};
                vy = '{-5 - d, d, d, d};
            end
            default: begin
                vx = '{-20 - d, 200, d, d};
                vy = '{400, 100 + d, d, d};
            end
        endcase
        o = '{kinds[slot % 8], 6'd0, color_t'(slot * 9 + 2),
              coord_t'(vy[3]), coord_t'(vx[3]), coord_t'(vy[2]), coord_t'(vx[2]),
              coord_t'(vy[1]), coord_t'(vx[1]), coord_t'(vy[0]), coord_t'(vx[0])};
        return o;
    endfunction

    function automatic logic [3:0] region(int x, int y);
        return {y > max_y, y < 0, x > max_x, x < 0};
    endfunction

    // edges in order ymax, ymin, xmax, xmin, flags taken from the original ends
    function automatic logic clip_ref(input int ax, input int ay, input int bx, input int by,
                                      input color_t col, output out_line_t res);
        logic [3:0] oc [2];
        int         px [2];
        int         py [2];
        int         edge_v;
        int         q;
        int         den;
        oc[0] = region(ax, ay);
        oc[1] = region(bx, by);
        px    = '{ax, bx};
        py    = '{ay, by};
        res   = '0;
        if ((oc[0] & oc[1]) != 4'b0) begin
            return 1'b0;
        end
        for (int e = 0; e < 4; e++) begin
            edge_v = (e == 0) ? max_y : (e == 2) ? max_x : 0;
            for (int p = 0; p < 2; p++) begin
                q = 1 - p;
                if (oc[p][3 - e] && e < 2) begin
                    den   = py[q] - py[p];
                    px[p] = px[p] + ((den == 0) ? 0 : (px[q] - px[p]) * (edge_v - py[p]) / den);
                    py[p] = edge_v;
                end else if (oc[p][3 - e]) begin
                    den   = px[q] - px[p];
                    py[p] = py[p] + ((den == 0) ? 0 : (py[q] - py[p]) * (edge_v - px[p]) / den);
                    px[p] = edge_v;
                end
            end
        end
        res = '{10'(px[0]), 10'(py[0]), 10'(px[1]), 10'(py[1]), col[2:0]};
        return 1'b1;
    endfunction

    task automatic expect_object(input object_t o);
        int        ox [4];
        int        oy [4];
        int        n;
        int        b;
        out_line_t res;
        ox = '{o.x0, o.x1, o.x2, o.x3};
        oy = '{o.y0, o.y1, o.y2, o.y3};
        case (o.kind)
            kind_point, kind_line: n = 1;
            kind_tri:              n = 3;
            default:               n = 4;
        endcase
        for (int a = 0; a < n; a++) begin
            b = (o.kind == kind_point) ? 0 : (a + 1) % ((o.kind == kind_tri) ? 3 : 4);
            if (clip_ref(ox[a], oy[a], ox[b], oy[b], o.color, res)) begin
                exp_q.push_back(res);
            end
        end
    endtask

    // object memory, data two cycles after read_en
    always @(posedge clk) begin
        rd_pend <= read_en;
        rd_addr <= addr;
        if (rd_pend) begin
            obj <= mem[rd_addr];
        end
    end

    always @(posedge clk) begin
        if (!rst_n || ready_hold) begin
            raster_ready <= 1'b0;
        end else begin
            raster_ready <= 1'($urandom % 2);
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            $display("timeout after %0d cycles, %0d lines never came out", cyc, exp_q.size());
            end_in_failure();
        end
    end

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (rst_n && vld) begin
            assert (exp_q.size() != 0) begin
                assert (line_out == exp_q[0]) begin
                    void'(exp_q.pop_front());
                end else begin
                    $display("Mismatch at %0t ns: line_out expected %s, got %s",
                             $time, fmt_line(exp_q[0]), fmt_line(line_out));
                    end_in_failure();
                end
            end else begin
                $display("vld raised at %0t ns with no line left to expect", $time);
                end_in_failure();
            end
        end
        if (i_clipping_unit.i_clipping_unit_assert.fail_cnt != 0) begin
            $display("a bound assertion failed at %0t ns", $time);
            end_in_failure();
        end
    end

    initial begin
        logic [num_slots-1:0] map;
        void'($urandom(60));
        rst_n   = 1'b0;
        obj_map = '0;
        for (int s = 0; s < num_slots; s++) begin
            mem[s] = make_obj(s);
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (150) @(posedge clk);   // halfway between scans
        for (int f = 0; f < 4; f++) begin
            map = (f < 3) ? $urandom : '0;
            if (f == 0) begin
                map = map | 32'hff;    // every object case at least once
            end
            obj_map    <= map;
            ready_hold <= f == 1;
            for (int s = 0; s < num_slots; s++) begin
                if (map[s]) begin
                    expect_object(mem[s]);
                end
            end
            repeat (refresh) @(posedge clk);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        if (i_clipping_unit.i_clipping_unit_assert.fail_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("bound assertions reported failures");
            end_in_failure();
        end
    end

endmodule

// File: tb/clipping_unit_assert.sv
module clipping_unit_assert (
    input logic                           clk,
    input logic                           rst_n,
    input logic [clip_pkg::num_slots-1:0] obj_map,
    input logic [4:0]                     addr,
    input logic                           read_en,
    input logic                           raster_ready,
    input logic                           vld
);
    timeunit 1ns;
    timeprecision 1ns;

    int unsigned fail_cnt = 0;  // watched by the testbench top

    // a read is only requested for an occupied slot
    a_read_map: assert property (@(posedge clk) disable iff (!rst_n)
        read_en |-> obj_map[addr])
    else begin
        fail_cnt++;
        $error("read_en for slot %0d whose map bit is clear", addr);
    end

    // phases 0 to 2 of the slot share one address
    a_addr_before: assert property (@(posedge clk) disable iff (!rst_n)
        read_en |-> $stable(addr) && (addr == $past(addr, 2)))
    else begin
        fail_cnt++;
        $error("addr moved within the slot before read_en");
    end

    a_addr_after: assert property (@(posedge clk) disable iff (!rst_n)
        $past(read_en) |-> $stable(addr))   // phase 3
    else begin
        fail_cnt++;
        $error("addr moved in the cycle after read_en");
    end

    a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        read_en |-> !$past(read_en))
    else begin
        fail_cnt++;
        $error("read_en held longer than one cycle");
    end

    // ready is registered once, then the pop shows up as vld
    a_vld_ready: assert property (@(posedge clk) disable iff (!rst_n)
        vld |-> $past(raster_ready, 2))
    else begin
        fail_cnt++;
        $error("vld without raster_ready two cycles before");
    end

    a_quiet_reset: assert property (@(posedge clk)
        !rst_n |-> !vld && !read_en)
    else begin
        fail_cnt++;
        $error("vld or read_en high during reset");
    end

endmodule

bind clipping_unit clipping_unit_assert i_clipping_unit_assert (
    .clk, .rst_n, .obj_map, .addr, .read_en, .raster_ready, .vld
);

// File: source/clipping_unit.sv
module clipping_unit #(
    parameter int refresh_period = 1666668,
    parameter int fifo_depth     = 128
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [clip_pkg::num_slots-1:0] obj_map,
    input  clip_pkg::object_t              obj,
    input  logic                           raster_ready,
    output logic [4:0]                     addr,
    output logic                           read_en,
    output clip_pkg::out_line_t            line_out,
    output logic                           vld
);
    import clip_pkg::*;

    object_t    obj_q;
    logic       obj_live;
    logic [1:0] phase;
    line_t      split_line;
    logic       split_wr;
    line_t      q_line;
    logic       q_empty;
    logic       q_rd;
    line_t      clip_line;
    logic       clip_wr;
    logic       o_full;
    line_t      o_line;
    logic       o_empty;
    logic       rdy_q;
    logic       pop;

    object_scanner #(.refresh_period(refresh_period)) i_object_scanner (
        .clk, .rst_n, .obj_map, .obj, .addr, .read_en,
        .obj_load (),
        .obj_live, .phase, .obj_q
    );

    line_splitter i_line_splitter (
        .clk, .rst_n, .obj_q, .obj_live, .phase,
        .line (split_line),
        .wr   (split_wr)
    );

    // sized for a whole frame of lines, so it never fills
    line_fifo #(.depth(fifo_depth), .width($bits(line_t))) i_line_queue (
        .clk, .rst_n,
        .wr (split_wr), .wdata (split_line),
        .rd (q_rd), .rdata (q_line),
        .empty (q_empty), .full ()
    );

    clip_engine i_clip_engine (
        .clk, .rst_n,
        .in_line (q_line), .in_empty (q_empty), .in_rd (q_rd),
        .out_line (clip_line), .out_wr (clip_wr), .out_full (o_full)
    );

    line_fifo #(.depth(fifo_depth), .width($bits(line_t))) i_out_queue (
        .clk, .rst_n,
        .wr (clip_wr), .wdata (clip_line),
        .rd (pop), .rdata (o_line),
        .empty (o_empty), .full (o_full)
    );

    assign pop = rdy_q && !o_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_q <= 1'b0;
            vld   <= 1'b0;
        end else begin
            rdy_q <= raster_ready;
            vld   <= pop;          // rdata shows up together with vld
        end
    end

    // rasterizer takes 10-bit coordinates and 3 bits of color
    assign line_out = '{x0: o_line.x0[9:0], y0: o_line.y0[9:0],
                        x1: o_line.x1[9:0], y1: o_line.y1[9:0],
                        color: o_line.color[2:0]};

endmodule

// File: source/clip_engine.sv
module clip_engine (
    input  logic            clk,
    input  logic            rst_n,
    input  clip_pkg::line_t in_line,
    input  logic            in_empty,
    output logic            in_rd,
    output clip_pkg::line_t out_line,
    output logic            out_wr,
    input  logic            out_full
);
    import clip_pkg::*;

    typedef enum logic [1:0] {st_idle, st_latch, st_decide, st_clip} state_t;

    state_t             st;
    state_t             nxt;
    coord_t             x0_w;
    coord_t             y0_w;
    coord_t             x1_w;
    coord_t             y1_w;
    color_t             color_w;
    outcode_t           oc0_l;      // outcodes as latched on entry
    outcode_t           oc1_l;
    logic               accept;
    logic               reject;
    logic [1:0]         step;       // diff, multiply, divide
    logic [1:0]         edge_idx;   // ymax, ymin, xmax, xmin
    logic               clip_done;
    logic               hit0;
    logic               hit1;
    logic               do_edge;
    logic               y_axis;
    coord_t             edge_val;
    coord_t             a_axis;
    coord_t             a_other;
    coord_t             b_axis;
    coord_t             b_other;
    coord_t             d_other;
    coord_t             d_edge;
    coord_t             d_axis;
    coord_t             div_r;
    coord_t             new_other;
    logic signed [31:0] prod;
    logic signed [31:0] quot;

    function automatic logic edge_flag(outcode_t oc, logic [1:0] e);
        case (e)
            2'd0:    return oc.gt_ymax;
            2'd1:    return oc.lt_ymin;
            2'd2:    return oc.gt_xmax;
            default: return oc.lt_xmin;
        endcase
    endfunction

    assign accept = (oc0_l | oc1_l) == 4'b0;
    assign reject = (oc0_l & oc1_l) != 4'b0; // both ends beyond the same edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) st <= st_idle;
        else        st <= nxt;
    end

    always_comb begin
        nxt    = st;
        in_rd  = 1'b0;
        out_wr = 1'b0;
        case (st)
            st_idle: begin
                if (!in_empty) begin
                    in_rd = 1'b1;
                    nxt   = st_latch;
                end
            end
            st_latch: nxt = st_decide;   // queue data arrives this cycle
            st_decide: begin
                if (reject) begin
                    nxt = st_idle;
                end else if (accept) begin
                    if (!out_full) begin
                        out_wr = 1'b1;
                        nxt    = st_idle;
                    end
                end else begin
                    nxt = st_clip;
                end
            end
            default: begin
                if (clip_done && !out_full) begin
                    out_wr = 1'b1;
                    nxt    = st_idle;
                end
            end
        endcase
    end

    // three cycles for each of the four edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step      <= 2'd0;
            edge_idx  <= 2'd0;
            clip_done <= 1'b0;
        end else if (st != st_clip) begin
            step      <= 2'd0;
            edge_idx  <= 2'd0;
            clip_done <= 1'b0;
        end else if (!clip_done) begin
            if (step == 2'd2) begin
                step      <= 2'd0;
                edge_idx  <= edge_idx + 2'd1;
                clip_done <= edge_idx == 2'd3;
            end else begin
                step <= step + 2'd1;
            end
        end
    end

    assign hit0    = edge_flag(oc0_l, edge_idx);
    assign hit1    = edge_flag(oc1_l, edge_idx);
    assign do_edge = hit0 | hit1;    // both set only on a rejected line
    assign y_axis  = !edge_idx[1];

    always_comb begin
        case (edge_idx)
            2'd0:    edge_val = screen_h;
            2'd2:    edge_val = screen_w;
            default: edge_val = '0;
        endcase
    end

    // endpoint a slides toward endpoint b
    assign a_axis  = y_axis ? (hit1 ? y1_w : y0_w) : (hit1 ? x1_w : x0_w);
    assign a_other = y_axis ? (hit1 ? x1_w : x0_w) : (hit1 ? y1_w : y0_w);
    assign b_axis  = y_axis ? (hit1 ? y0_w : y1_w) : (hit1 ? x0_w : x1_w);
    assign b_other = y_axis ? (hit1 ? x0_w : x1_w) : (hit1 ? y0_w : y1_w);

    always_ff @(posedge clk) begin
        d_other <= b_other - a_other;
        d_edge  <= edge_val - a_axis;
        d_axis  <= b_axis - a_axis;
        prod    <= d_other * d_edge;
        div_r   <= d_axis;
    end

    assign quot      = (div_r == '0) ? 32'sd0 : prod / div_r; // truncates toward zero
    assign new_other = a_other + coord_t'(quot[15:0]);

    always_ff @(posedge clk) begin
        if (st == st_latch) begin
            x0_w    <= in_line.x0;
            y0_w    <= in_line.y0;
            x1_w    <= in_line.x1;
            y1_w    <= in_line.y1;
            color_w <= in_line.color;
            oc0_l   <= in_line.oc0;
            oc1_l   <= in_line.oc1;
        end else if (st == st_clip && step == 2'd2 && do_edge) begin
            if (hit1) begin
                if (y_axis) begin
                    y1_w <= edge_val;
                    x1_w <= new_other;
                end else begin
                    x1_w <= edge_val;
                    y1_w <= new_other;
                end
            end else if (y_axis) begin
                y0_w <= edge_val;
                x0_w <= new_other;
            end else begin
                x0_w <= edge_val;
                y0_w <= new_other;
            end
        end
    end

    // entry outcodes ride along unread downstream
    assign out_line = '{x0: x0_w, y0: y0_w, x1: x1_w, y1: y1_w,
                        color: color_w, oc0: oc0_l, oc1: oc1_l};

endmodule

// File: source/line_fifo.sv
module line_fifo #(
    parameter int depth = 128,
    parameter int width = 80
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr,
    input  logic [width-1:0] wdata,
    input  logic             rd,
    output logic [width-1:0] rdata,
    output logic             empty,
    output logic             full
);

    localparam int aw = $clog2(depth);

    logic [width-1:0] mem [depth];
    logic [aw-1:0]    wptr;
    logic [aw-1:0]    rptr;
    logic [aw:0]      count;  // entries currently stored
    logic             do_wr;
    logic             do_rd;

    function automatic logic [aw-1:0] next_ptr(logic [aw-1:0] p);
        return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr = wr && !full;   // writes into a full queue are dropped
    assign do_rd = rd && !empty;
    assign empty = count == '0;
    assign full  = count == (aw + 1)'(depth);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) wptr <= next_ptr(wptr);
            if (do_rd) rptr <= next_ptr(rptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= wdata;
        end
        if (do_rd) begin
            rdata <= mem[rptr];   // valid the cycle after rd
        end
    end

endmodule

// File: source/line_splitter.sv
module line_splitter (
    input  logic              clk,
    input  logic              rst_n,
    input  clip_pkg::object_t obj_q,
    input  logic              obj_live,
    input  logic [1:0]        phase,
    output clip_pkg::line_t   line,
    output logic              wr
);
    import clip_pkg::*;

    coord_t     vx [4];
    coord_t     vy [4];
    logic [1:0] ia;      // start vertex of this phase's line
    logic [1:0] ib;      // end vertex
    logic       sel_vld;

    function automatic outcode_t outcode(coord_t x, coord_t y);
        outcode_t oc;
        oc.gt_ymax = y > screen_h;
        oc.lt_ymin = y < 0;
        oc.gt_xmax = x > screen_w;
        oc.lt_xmin = x < 0;
        return oc;
    endfunction

    assign vx[0] = obj_q.x0;
    assign vy[0] = obj_q.y0;
    assign vx[1] = obj_q.x1;
    assign vy[1] = obj_q.y1;
    assign vx[2] = obj_q.x2;
    assign vy[2] = obj_q.y2;
    assign vx[3] = obj_q.x3;
    assign vy[3] = obj_q.y3;

    // phase n draws vertex n to n+1, closing edges wrap back to v0
    always_comb begin
        ia      = phase;
        ib      = phase + 2'd1;
        sel_vld = 1'b0;
        case (obj_q.kind)
            kind_point: begin
                sel_vld = phase == 2'd0;
                ib      = 2'd0;          // degenerate line v0 to v0
            end
            kind_line: begin
                sel_vld = phase == 2'd0;
            end
            kind_tri: begin
                sel_vld = phase != 2'd3;
                if (phase == 2'd2) begin
                    ib = 2'd0;
                end
            end
            default: begin
                sel_vld = 1'b1;          // quad, v3 to v0 wraps by itself
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr <= 1'b0;
        end else begin
            wr <= obj_live && sel_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (obj_live && sel_vld) begin
            line.x0    <= vx[ia];
            line.y0    <= vy[ia];
            line.x1    <= vx[ib];
            line.y1    <= vy[ib];
            line.color <= obj_q.color;
            line.oc0   <= outcode(vx[ia], vy[ia]);
            line.oc1   <= outcode(vx[ib], vy[ib]);
        end
    end

endmodule

// File: source/object_scanner.sv
module object_scanner #(
    parameter int refresh_period = 1666668
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [clip_pkg::num_slots-1:0] obj_map,
    input  clip_pkg::object_t              obj,
    output logic [4:0]                     addr,
    output logic                           read_en,
    output logic                           obj_load,
    output logic                           obj_live,
    output logic [1:0]                     phase,
    output clip_pkg::object_t              obj_q
);
    import clip_pkg::*;

    localparam int cnt_w     = $clog2(refresh_period);
    localparam int last_slot = num_slots + 1; // two extra slots drain the pipeline

    logic [cnt_w-1:0] refresh_cnt;
    logic             wrap;
    logic             busy;
    logic [5:0]       slot;
    logic             scanning;
    logic             read_d1;
    logic             got_obj;
    object_t          obj_hold;

    assign wrap     = refresh_cnt == cnt_w'(refresh_period - 1);
    assign scanning = busy && (slot < 6'(num_slots));
    assign addr     = scanning ? slot[4:0] : 5'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt <= '0;
        end else if (wrap) begin
            refresh_cnt <= '0;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // four cycles per slot, map slots first and then the drain slots
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            slot  <= '0;
            phase <= 2'd0;
        end else if (!busy) begin
            busy  <= wrap;        // scan begins the cycle after the wrap
            slot  <= '0;
            phase <= 2'd0;
        end else begin
            phase <= phase + 2'd1;
            if (phase == 2'd3) begin
                if (slot == 6'(last_slot)) begin
                    busy <= 1'b0;
                    slot <= '0;
                end else begin
                    slot <= slot + 6'd1;
                end
            end
        end
    end

    // read request lands on phase 2, the object comes back on phase 0 of the next slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_en  <= 1'b0;
            read_d1  <= 1'b0;
            obj_load <= 1'b0;
        end else begin
            read_en  <= scanning && (phase == 2'd1) && obj_map[addr];
            read_d1  <= read_en;
            obj_load <= read_d1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            got_obj  <= 1'b0;
            obj_live <= 1'b0;
        end else if (busy && phase == 2'd3) begin
            obj_live <= got_obj;  // split during the whole next slot
            got_obj  <= 1'b0;
        end else if (obj_load) begin
            got_obj  <= 1'b1;
        end
    end

    // hold register frees obj_q while the previous object is still being split
    always_ff @(posedge clk) begin
        if (obj_load) begin
            obj_hold <= obj;
        end
        if (busy && phase == 2'd3) begin
            obj_q <= obj_hold;
        end
    end

endmodule

// File: source/clip_pkg.sv
package clip_pkg;

    // clip window edges, a point sitting exactly on an edge is inside
    localparam logic signed [15:0] screen_w = 16'sd640;
    localparam logic signed [15:0] screen_h = 16'sd480;

    localparam int num_slots = 32; // object slots walked per frame scan

    typedef logic signed [15:0] coord_t;
    typedef logic [7:0]         color_t;

    // region flags of one endpoint, msb first
    typedef struct packed {
        logic gt_ymax;
        logic lt_ymin;
        logic gt_xmax;
        logic lt_xmin;
    } outcode_t;

    typedef enum logic [1:0] {
        kind_point = 2'd0,
        kind_line  = 2'd1,
        kind_tri   = 2'd2,
        kind_quad  = 2'd3
    } obj_kind_t;

    // object memory word: kind in 143:142, color in 135:128, x0 in 15:0
    typedef struct packed {
        obj_kind_t  kind;
        logic [5:0] pad;   // unused
        color_t     color;
        coord_t     y3;
        coord_t     x3;
        coord_t     y2;
        coord_t     x2;
        coord_t     y1;
        coord_t     x1;
        coord_t     y0;
        coord_t     x0;
    } object_t;

    // one line as it travels through both queues
    typedef struct packed {
        coord_t   x0;
        coord_t   y0;
        coord_t   x1;
        coord_t   y1;
        color_t   color;
        outcode_t oc0;
        outcode_t oc1;
    } line_t;

    // rasterizer side, screen coordinates fit in 10 bits
    typedef struct packed {
        logic [9:0] x0;
        logic [9:0] y0;
        logic [9:0] x1;
        logic [9:0] y1;
        logic [2:0] color;
    } out_line_t;

endpackage
